// File: compile.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
decode/fetch_latch.sv
decode/main_control.sv
decode/operand_decode.sv
hw/reg_file.sv
hw/id_ex_reg.sv
hw/decode_top.sv
test/tb_decode_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_decode_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qx "Testbench passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: test/tb_decode_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module tb_decode_top
  import isa_pkg::*;
  import ctrl_pkg::*;
;

  localparam int N_SENDS      = 48;
  localparam int CYC_PER_SEND = 3;
  localparam int EXTRA_CYCLES = 40;
  localparam int MAX_CYCLES   = N_SENDS * CYC_PER_SEND + EXTRA_CYCLES + 100;

  logic        i_clk = 1'b0;
  logic        i_arst_n;
  logic [31:0] i_instr, i_pc, i_wb_data;
  logic        i_instr_valid, i_stall, i_flush, i_wb_we;
  logic [4:0]  i_wb_addr;
  ex_ctrl_t    o_ex;
  mem_ctrl_t   o_mem;
  wb_ctrl_t    o_wb;
  mem_size_t   o_sizemem;
  logic        o_signedmem, o_beq_or_bne, o_valid, o_halted, o_jump;
  logic [31:0] o_rs_data, o_rt_data, o_imm, o_pc, o_jump_target;
  logic [4:0]  o_wr_reg;

  logic [31:0] lfsr = 32'he98fe37d;
  logic [31:0] shadow [32];
  int          err_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          test_err_start;
  int          cycles = 0;

  decode_top decode_top_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_instr(i_instr), .i_pc(i_pc),
    .i_instr_valid(i_instr_valid), .i_stall(i_stall), .i_flush(i_flush),
    .i_wb_we(i_wb_we), .i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data),
    .o_ex(o_ex), .o_mem(o_mem), .o_wb(o_wb), .o_sizemem(o_sizemem),
    .o_signedmem(o_signedmem), .o_beq_or_bne(o_beq_or_bne),
    .o_rs_data(o_rs_data), .o_rt_data(o_rt_data), .o_imm(o_imm),
    .o_wr_reg(o_wr_reg), .o_pc(o_pc), .o_valid(o_valid), .o_halted(o_halted),
    .o_jump(o_jump), .o_jump_target(o_jump_target)
  );

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // Halt stays set and every later capture is a bubble
  assert property (@(posedge i_clk) disable iff (!i_arst_n) o_halted |=> o_halted && !o_valid)
    else begin
      $display("Halt flag dropped or a valid instruction passed after halt");
      err_count++;
    end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic        nb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], nb};
      v    = {v[30:0], nb};
    end
    return v;
  endfunction

  // {ex, mem, wb, size, signed, beq}
  function automatic logic [12:0] ctrl_ref(input logic [5:0] op);
    case (op)
      R_TYPE:                         return 13'b1010_000_11_00_0_0;
      LW:                             return 13'b0100_100_10_00_1_0;
      LWU:                            return 13'b0100_100_10_00_0_0;
      LB:                             return 13'b0100_100_10_01_1_0;
      LBU:                            return 13'b0100_100_10_01_0_0;
      LH:                             return 13'b0100_100_10_10_1_0;
      LHU:                            return 13'b0100_100_10_10_0_0;
      SW:                             return 13'b0100_010_00_00_0_0;
      SB:                             return 13'b0100_010_00_01_0_0;
      SH:                             return 13'b0100_010_00_10_0_0;
      BEQ:                            return 13'b0001_001_00_00_0_1;
      BNE:                            return 13'b0001_001_00_00_0_0;
      ADDI, ANDI, ORI, XORI, LUI, SLTI: return 13'b0111_000_11_00_0_0;
      NOP, HALT:                      return 13'b0011_000_00_00_0_0;
      default:                        return 13'b0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_jump(input logic [31:0] instr, input logic [31:0] pc);
    logic        exp_j;
    logic [31:0] pc4;
    exp_j = (instr[31:26] == J) || (instr[31:26] == JAL);
    pc4   = pc + 32'd4;
    check_val("o_jump", 32'(o_jump), 32'(exp_j));
    if (exp_j) begin
      check_val("o_jump_target", o_jump_target, {pc4[31:28], instr[25:0], 2'b00});
    end
  endtask

  task automatic check_decode(input logic [31:0] instr, input logic [31:0] pc,
                              input logic exp_valid);
    logic [12:0] c;
    logic [5:0]  op;
    logic [31:0] imm;
    op = instr[31:26];
    c  = exp_valid ? ctrl_ref(op) : 13'b0;
    if (op == ANDI || op == ORI || op == XORI) begin
      imm = {16'h0, instr[15:0]};
    end else if (op == LUI) begin
      imm = {instr[15:0], 16'h0};
    end else begin
      imm = {{16{instr[15]}}, instr[15:0]};
    end
    check_val("o_valid", 32'(o_valid), 32'(exp_valid));
    check_val("o_ex", 32'(o_ex), 32'(c[12:9]));
    check_val("o_mem", 32'(o_mem), 32'(c[8:6]));
    check_val("o_wb", 32'(o_wb), 32'(c[5:4]));
    check_val("o_sizemem", 32'(o_sizemem), 32'(c[3:2]));
    check_val("o_signedmem", 32'(o_signedmem), 32'(c[1]));
    check_val("o_beq_or_bne", 32'(o_beq_or_bne), 32'(c[0]));
    if (exp_valid) begin
      check_val("o_imm", o_imm, imm);
      check_val("o_wr_reg", 32'(o_wr_reg), 32'(op == R_TYPE ? instr[15:11] : instr[20:16]));
      check_val("o_pc", o_pc, pc);
      check_val("o_rs_data", o_rs_data, shadow[instr[25:21]]);
      check_val("o_rt_data", o_rt_data, shadow[instr[20:16]]);
    end
  endtask

  // Jump one cycle after input, decoded fields after two
  task automatic send(input logic [31:0] instr, input logic [31:0] pc, input logic exp_valid);
    @(negedge i_clk);
    i_instr       = instr;
    i_pc          = pc;
    i_instr_valid = 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    i_instr_valid = 1'b0;
    check_jump(instr, pc);
    @(posedge i_clk);
    @(negedge i_clk);
    check_decode(instr, pc, exp_valid);
  endtask

  task automatic send_op(input logic [5:0] op, input logic exp_valid);
    logic [31:0] f, pc;
    f  = rand_bits(26);
    pc = rand_bits(30);
    send({op, f[25:0]}, {pc[29:0], 2'b00}, exp_valid);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(negedge i_clk);
    i_wb_we   = 1'b1;
    i_wb_addr = addr;
    i_wb_data = data;
    @(posedge i_clk);
    @(negedge i_clk);
    i_wb_we = 1'b0;
    if (addr != 5'd0) begin
      shadow[addr] = data;
    end
  endtask

  task automatic apply_reset();
    i_arst_n = 1'b0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
  endtask

  task automatic test_begin();
    test_err_start = err_count;
  endtask

  task automatic test_end(input string name);
    if (err_count == test_err_start) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, err_count - test_err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  initial begin
    logic [5:0]  ops [$];
    logic [31:0] d, instr;
    i_arst_n = 1'b0;
    i_instr = '0;
    i_pc = '0;
    i_instr_valid = 1'b0;
    i_stall = 1'b0;
    i_flush = 1'b0;
    i_wb_we = 1'b0;
    i_wb_addr = '0;
    i_wb_data = '0;
    apply_reset();

    test_begin();
    check_val("o_valid", 32'(o_valid), 32'h0);
    check_val("o_halted", 32'(o_halted), 32'h0);
    ops = '{R_TYPE, LW, LWU, LB, LBU, LH, LHU, SW, SB, SH, BEQ, BNE, ADDI, ANDI,
            ORI, XORI, LUI, SLTI, NOP, J, JAL, 6'b010101};
    foreach (ops[i]) send_op(ops[i], 1'b1);
    test_end("control table");

    test_begin();
    ops = '{R_TYPE, LW, SW, BEQ, ADDI, SLTI, ANDI, ORI, XORI, LUI};
    foreach (ops[i]) send_op(ops[i], 1'b1);
    test_end("immediate and destination");

    test_begin();
    for (int i = 0; i < 4; i++) begin
      d = rand_bits(32);
      write_reg(5'(i + 3), d);
    end
    write_reg(5'd0, 32'hdeadbeef);
    send({R_TYPE, 5'd3, 5'd4, 5'd9, 11'd0}, 32'h100, 1'b1);
    send({ADDI, 5'd0, 5'd6, 16'h1234}, 32'h104, 1'b1);
    // Same-cycle write to rs while the instruction sits in IF/ID
    instr = {R_TYPE, 5'd5, 5'd6, 5'd7, 11'd0};
    @(negedge i_clk);
    i_instr = instr;
    i_pc = 32'h108;
    i_instr_valid = 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    i_instr_valid = 1'b0;
    d = rand_bits(32);
    i_wb_we = 1'b1;
    i_wb_addr = 5'd5;
    i_wb_data = d;
    shadow[5] = d;
    @(posedge i_clk);
    @(negedge i_clk);
    i_wb_we = 1'b0;
    check_decode(instr, 32'h108, 1'b1);
    test_end("register file");

    test_begin();
    instr = {LW, 5'd3, 5'd4, 16'h8000};
    @(negedge i_clk);
    i_instr = instr;
    i_pc = 32'h200;
    i_instr_valid = 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    i_instr_valid = 1'b0;
    i_stall = 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    i_stall = 1'b0;
    check_decode(instr, 32'h200, 1'b0);
    @(posedge i_clk);
    @(negedge i_clk);
    check_decode(instr, 32'h200, 1'b1);
    @(posedge i_clk);
    @(negedge i_clk);
    check_val("o_valid", 32'(o_valid), 32'h0);
    // Flush at the same edge that would latch the instruction
    i_instr = {J, 26'h3ffffff};
    i_instr_valid = 1'b1;
    i_flush = 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    i_instr_valid = 1'b0;
    i_flush = 1'b0;
    check_val("o_jump", 32'(o_jump), 32'h0);
    @(posedge i_clk);
    @(negedge i_clk);
    check_decode(i_instr, 32'h0, 1'b0);
    test_end("stall and flush");

    test_begin();
    send({J, 26'h2abcdef}, 32'hf000_0ffc, 1'b1);
    send({JAL, 26'h0000123}, 32'h7fff_fffc, 1'b1);
    test_end("jump");

    test_begin();
    send_op(HALT, 1'b1);
    check_val("o_halted", 32'(o_halted), 32'h1);
    send_op(ADDI, 1'b0);
    send_op(R_TYPE, 1'b0);
    check_val("o_halted", 32'(o_halted), 32'h1);
    apply_reset();
    check_val("o_halted", 32'(o_halted), 32'h0);
    check_val("o_valid", 32'(o_valid), 32'h0);
    send_op(ORI, 1'b1);
    test_end("halt");

    $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decode_top
  import isa_pkg::*;
  import ctrl_pkg::*;
(
  input  wire logic                       i_clk,
  input  wire logic                       i_arst_n,
  input  wire logic [`DATA_WIDTH-1:0]     i_instr,
  input  wire logic [`DATA_WIDTH-1:0]     i_pc,
  input  wire logic                       i_instr_valid,
  input  wire logic                       i_stall,
  input  wire logic                       i_flush,
  input  wire logic                       i_wb_we,
  input  wire logic [`REG_ADDR_WIDTH-1:0] i_wb_addr,
  input  wire logic [`DATA_WIDTH-1:0]     i_wb_data,
  output ex_ctrl_t                        o_ex,
  output mem_ctrl_t                       o_mem,
  output wb_ctrl_t                        o_wb,
  output mem_size_t                       o_sizemem,
  output logic                            o_signedmem,
  output logic                            o_beq_or_bne,
  output logic      [`DATA_WIDTH-1:0]     o_rs_data,
  output logic      [`DATA_WIDTH-1:0]     o_rt_data,
  output logic      [`DATA_WIDTH-1:0]     o_imm,
  output logic      [`REG_ADDR_WIDTH-1:0] o_wr_reg,
  output logic      [`DATA_WIDTH-1:0]     o_pc,
  output logic                            o_valid,
  output logic                            o_halted,
  output logic                            o_jump,
  output logic      [`DATA_WIDTH-1:0]     o_jump_target
);

  logic [`DATA_WIDTH-1:0]     if_instr;
  logic [`DATA_WIDTH-1:0]     if_pc;
  logic                       if_valid;
  ex_ctrl_t                   ctl_ex;
  mem_ctrl_t                  ctl_mem;
  wb_ctrl_t                   ctl_wb;
  mem_size_t                  ctl_sizemem;
  logic                       ctl_signedmem;
  logic                       ctl_beq_or_bne;
  logic [`DATA_WIDTH-1:0]     imm;
  logic [`REG_ADDR_WIDTH-1:0] rs_addr;
  logic [`REG_ADDR_WIDTH-1:0] rt_addr;
  logic [`REG_ADDR_WIDTH-1:0] wr_reg;
  logic [`DATA_WIDTH-1:0]     rs_data;
  logic [`DATA_WIDTH-1:0]     rt_data;
  logic                       opcode_halt;

  assign opcode_halt = (if_instr[OP_HI:OP_LO] == HALT);

  //////////////////////////////////////////////////
  // IF/ID
  //////////////////////////////////////////////////
  fetch_latch fetch_latch_inst (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_instr  (i_instr),
    .i_pc     (i_pc),
    .i_valid  (i_instr_valid),
    .i_stall  (i_stall),
    .i_flush  (i_flush),
    .o_instr  (if_instr),
    .o_pc     (if_pc),
    .o_valid  (if_valid)
  );

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  main_control main_control_inst (
    .i_instr      (if_instr),
    .o_ex         (ctl_ex),
    .o_mem        (ctl_mem),
    .o_wb         (ctl_wb),
    .o_sizemem    (ctl_sizemem),
    .o_signedmem  (ctl_signedmem),
    .o_beq_or_bne (ctl_beq_or_bne)
  );

  operand_decode operand_decode_inst (
    .i_instr       (if_instr),
    .i_pc          (if_pc),
    .i_valid       (if_valid),
    .o_imm         (imm),
    .o_rs_addr     (rs_addr),
    .o_rt_addr     (rt_addr),
    .o_wr_reg      (wr_reg),
    .o_jump        (o_jump),
    .o_jump_target (o_jump_target)
  );

  reg_file reg_file_inst (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs_addr (rs_addr),
    .i_rt_addr (rt_addr),
    .i_we      (i_wb_we),
    .i_wr_addr (i_wb_addr),
    .i_wr_data (i_wb_data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  //////////////////////////////////////////////////
  // ID/EX
  //////////////////////////////////////////////////
  id_ex_reg id_ex_reg_inst (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_stall       (i_stall),
    .i_valid       (if_valid),
    .i_opcode_halt (opcode_halt),
    .i_ex          (ctl_ex),
    .i_mem         (ctl_mem),
    .i_wb          (ctl_wb),
    .i_sizemem     (ctl_sizemem),
    .i_signedmem   (ctl_signedmem),
    .i_beq_or_bne  (ctl_beq_or_bne),
    .i_rs_data     (rs_data),
    .i_rt_data     (rt_data),
    .i_imm         (imm),
    .i_wr_reg      (wr_reg),
    .i_pc          (if_pc),
    .o_ex          (o_ex),
    .o_mem         (o_mem),
    .o_wb          (o_wb),
    .o_sizemem     (o_sizemem),
    .o_signedmem   (o_signedmem),
    .o_beq_or_bne  (o_beq_or_bne),
    .o_rs_data     (o_rs_data),
    .o_rt_data     (o_rt_data),
    .o_imm         (o_imm),
    .o_wr_reg      (o_wr_reg),
    .o_pc          (o_pc),
    .o_valid       (o_valid),
    .o_halted      (o_halted)
  );

endmodule

`default_nettype wire

// File: hw/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module id_ex_reg
  import ctrl_pkg::*;
(
  input  wire logic                       i_clk,
  input  wire logic                       i_arst_n,
  input  wire logic                       i_stall,
  input  wire logic                       i_valid,
  input  wire logic                       i_opcode_halt,
  input  wire ex_ctrl_t                   i_ex,
  input  wire mem_ctrl_t                  i_mem,
  input  wire wb_ctrl_t                   i_wb,
  input  wire mem_size_t                  i_sizemem,
  input  wire logic                       i_signedmem,
  input  wire logic                       i_beq_or_bne,
  input  wire logic [`DATA_WIDTH-1:0]     i_rs_data,
  input  wire logic [`DATA_WIDTH-1:0]     i_rt_data,
  input  wire logic [`DATA_WIDTH-1:0]     i_imm,
  input  wire logic [`REG_ADDR_WIDTH-1:0] i_wr_reg,
  input  wire logic [`DATA_WIDTH-1:0]     i_pc,
  output ex_ctrl_t                        o_ex,
  output mem_ctrl_t                       o_mem,
  output wb_ctrl_t                        o_wb,
  output mem_size_t                       o_sizemem,
  output logic                            o_signedmem,
  output logic                            o_beq_or_bne,
  output logic      [`DATA_WIDTH-1:0]     o_rs_data,
  output logic      [`DATA_WIDTH-1:0]     o_rt_data,
  output logic      [`DATA_WIDTH-1:0]     o_imm,
  output logic      [`REG_ADDR_WIDTH-1:0] o_wr_reg,
  output logic      [`DATA_WIDTH-1:0]     o_pc,
  output logic                            o_valid,
  output logic                            o_halted
);

  logic take;

  // Anything not taken enters as a bubble
  assign take = i_valid && !i_stall && !o_halted;

  //////////////////////////////////////////////////
  // Control and halt state
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex         <= '0;
      o_mem        <= '0;
      o_wb         <= '0;
      o_sizemem    <= WORD;
      o_signedmem  <= 1'b0;
      o_beq_or_bne <= 1'b0;
      o_valid      <= 1'b0;
      o_halted     <= 1'b0;
    end else begin
      o_ex         <= take ? i_ex : '0;
      o_mem        <= take ? i_mem : '0;
      o_wb         <= take ? i_wb : '0;
      o_sizemem    <= take ? i_sizemem : WORD;
      o_signedmem  <= take && i_signedmem;
      o_beq_or_bne <= take && i_beq_or_bne;
      o_valid      <= take;
      // Sticky until reset
      o_halted     <= o_halted || (take && i_opcode_halt);
    end
  end

  // Operands
  always_ff @(posedge i_clk) begin
    o_rs_data <= i_rs_data;
    o_rt_data <= i_rt_data;
    o_imm     <= i_imm;
    o_wr_reg  <= i_wr_reg;
    o_pc      <= i_pc;
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module reg_file (
  input  wire logic                       i_clk,
  input  wire logic                       i_arst_n,
  input  wire logic [`REG_ADDR_WIDTH-1:0] i_rs_addr,
  input  wire logic [`REG_ADDR_WIDTH-1:0] i_rt_addr,
  input  wire logic                       i_we,
  input  wire logic [`REG_ADDR_WIDTH-1:0] i_wr_addr,
  input  wire logic [`DATA_WIDTH-1:0]     i_wr_data,
  output logic      [`DATA_WIDTH-1:0]     o_rs_data,
  output logic      [`DATA_WIDTH-1:0]     o_rt_data
);

  localparam int unsigned NUM_REGS = 2 ** `REG_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // r0 reads zero, otherwise a same-cycle write is bypassed
  assign o_rs_data = (i_rs_addr == '0)                ? '0 :
                     (i_we && (i_wr_addr == i_rs_addr)) ? i_wr_data : regs[i_rs_addr];
  assign o_rt_data = (i_rt_addr == '0)                ? '0 :
                     (i_we && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

endmodule

`default_nettype wire

// File: decode/operand_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module operand_decode
  import isa_pkg::*;
(
  input  wire logic [`DATA_WIDTH-1:0]     i_instr,
  input  wire logic [`DATA_WIDTH-1:0]     i_pc,
  input  wire logic                       i_valid,
  output logic      [`DATA_WIDTH-1:0]     o_imm,
  output logic      [`REG_ADDR_WIDTH-1:0] o_rs_addr,
  output logic      [`REG_ADDR_WIDTH-1:0] o_rt_addr,
  output logic      [`REG_ADDR_WIDTH-1:0] o_wr_reg,
  output logic                            o_jump,
  output logic      [`DATA_WIDTH-1:0]     o_jump_target
);

  localparam int unsigned IMM_W = IMM_HI - IMM_LO + 1;

  opcode_t                opcode;
  logic [IMM_W-1:0]       imm;
  logic [`DATA_WIDTH-1:0] pc_plus4;

  assign opcode   = opcode_t'(i_instr[OP_HI:OP_LO]);
  assign imm      = i_instr[IMM_HI:IMM_LO];
  assign pc_plus4 = i_pc + `DATA_WIDTH'(4);

  // Logical immediates zero-extend, LUI shifts to the upper half
  always_comb begin
    case (opcode)
      ANDI, ORI, XORI: o_imm = {{(`DATA_WIDTH-IMM_W){1'b0}}, imm};
      LUI:             o_imm = {imm, {(`DATA_WIDTH-IMM_W){1'b0}}};
      default:         o_imm = {{(`DATA_WIDTH-IMM_W){imm[IMM_W-1]}}, imm};
    endcase
  end

  assign o_rs_addr = i_instr[RS_HI:RS_LO];
  assign o_rt_addr = i_instr[RT_HI:RT_LO];
  assign o_wr_reg  = (opcode == R_TYPE) ? i_instr[RD_HI:RD_LO] : i_instr[RT_HI:RT_LO];

  //////////////////////////////////////////////////
  // Early jump resolution
  //////////////////////////////////////////////////
  assign o_jump        = i_valid && ((opcode == J) || (opcode == JAL));
  assign o_jump_target = {pc_plus4[`DATA_WIDTH-1 -: 4], i_instr[JIDX_HI:JIDX_LO], 2'b00};

endmodule

`default_nettype wire

// File: decode/main_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module main_control
  import isa_pkg::*;
  import ctrl_pkg::*;
(
  input  wire logic [`DATA_WIDTH-1:0] i_instr,
  output ex_ctrl_t                    o_ex,
  output mem_ctrl_t                   o_mem,
  output wb_ctrl_t                    o_wb,
  output mem_size_t                   o_sizemem,
  output logic                        o_signedmem,
  output logic                        o_beq_or_bne
);

  opcode_t opcode;

  assign opcode = opcode_t'(i_instr[OP_HI:OP_LO]);

  //////////////////////////////////////////////////
  // Stage control fields
  //////////////////////////////////////////////////
  always_comb begin
    o_ex         = '0;
    o_mem        = '0;
    o_wb         = '0;
    o_beq_or_bne = 1'b0;
    case (opcode)
      R_TYPE: begin
        o_ex  = 4'b1010;
        o_wb  = 2'b11;
      end
      LW, LWU, LB, LBU, LH, LHU: begin
        o_ex  = 4'b0100;
        o_mem = 3'b100;
        o_wb  = 2'b10;
      end
      SW, SB, SH: begin
        o_ex  = 4'b0100;
        o_mem = 3'b010;
      end
      BEQ, BNE: begin
        o_ex         = 4'b0001;
        o_mem        = 3'b001;
        // High selects equal compare
        o_beq_or_bne = (opcode == BEQ);
      end
      ADDI, ANDI, ORI, XORI, LUI, SLTI: begin
        o_ex  = 4'b0111;
        o_wb  = 2'b11;
      end
      NOP, HALT: begin
        o_ex  = 4'b0011;
      end
      // J, JAL and undefined opcodes stay all zero
      default: begin
        o_ex  = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Memory access size and sign
  //////////////////////////////////////////////////
  always_comb begin
    o_sizemem   = WORD;
    o_signedmem = 1'b0;
    case (opcode)
      LW: begin
        o_signedmem = 1'b1;
      end
      LB: begin
        o_sizemem   = BYTE;
        o_signedmem = 1'b1;
      end
      LH: begin
        o_sizemem   = HALF;
        o_signedmem = 1'b1;
      end
      LBU, SB: o_sizemem = BYTE;
      LHU, SH: o_sizemem = HALF;
      default: o_sizemem = WORD;
    endcase
  end

endmodule

`default_nettype wire

// File: decode/fetch_latch.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module fetch_latch
  import isa_pkg::*;
(
  input  wire logic                   i_clk,
  input  wire logic                   i_arst_n,
  input  wire logic [`DATA_WIDTH-1:0] i_instr,
  input  wire logic [`DATA_WIDTH-1:0] i_pc,
  input  wire logic                   i_valid,
  input  wire logic                   i_stall,
  input  wire logic                   i_flush,
  output logic      [`DATA_WIDTH-1:0] o_instr,
  output logic      [`DATA_WIDTH-1:0] o_pc,
  output logic                        o_valid
);

  // NOP with all operand fields zero
  localparam logic [`DATA_WIDTH-1:0] NOP_INSTR = {NOP, {(`DATA_WIDTH-`OPCODE_WIDTH){1'b0}}};

  // Flush takes priority over stall
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_instr <= NOP_INSTR;
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_instr <= NOP_INSTR;
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_instr <= i_instr;
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_pc <= i_pc;
    end
  end

endmodule

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // Execute stage controls
  typedef struct packed {
    logic       reg_dst;
    logic       alu_src;
    logic [1:0] alu_op;
  } ex_ctrl_t;

  // Memory stage controls
  typedef struct packed {
    logic mem_read;
    logic mem_write;
    logic branch;
  } mem_ctrl_t;

  // Writeback controls, alu_result low selects load data
  typedef struct packed {
    logic reg_write;
    logic alu_result;
  } wb_ctrl_t;

  // Load/store access size
  typedef enum logic [1:0] {
    WORD = 2'b00,
    BYTE = 2'b01,
    HALF = 2'b10
  } mem_size_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

`include "decode_params.svh"

package isa_pkg;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    R_TYPE = 6'b000000,
    LW     = 6'b100011,
    LWU    = 6'b100111,
    LB     = 6'b100000,
    LBU    = 6'b100100,
    LH     = 6'b100001,
    LHU    = 6'b100101,
    SW     = 6'b101011,
    SB     = 6'b101000,
    SH     = 6'b101001,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    ADDI   = 6'b001000,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    XORI   = 6'b001110,
    LUI    = 6'b001111,
    SLTI   = 6'b001010,
    J      = 6'b000010,
    JAL    = 6'b000011,
    NOP    = 6'b111000,
    HALT   = 6'b111111
  } opcode_t;

  //////////////////////////////////////////////////
  // Instruction field positions
  //////////////////////////////////////////////////
  localparam int unsigned OP_HI   = 31;
  localparam int unsigned OP_LO   = 26;
  localparam int unsigned RS_HI   = 25;
  localparam int unsigned RS_LO   = 21;
  localparam int unsigned RT_HI   = 20;
  localparam int unsigned RT_LO   = 16;
  localparam int unsigned RD_HI   = 15;
  localparam int unsigned RD_LO   = 11;
  localparam int unsigned IMM_HI  = 15;
  localparam int unsigned IMM_LO  = 0;
  localparam int unsigned JIDX_HI = 25;
  localparam int unsigned JIDX_LO = 0;

endpackage

`default_nettype wire

// File: common/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Instruction and register data width
`define DATA_WIDTH 32

// Primary opcode field
`define OPCODE_WIDTH 6

// Register file address, 32 entries
`define REG_ADDR_WIDTH 5

`endif
